// ==== hdl/cart_pkg.sv ====
// cartridge header definitions
package cart_pkg;

	//////////////////////////////////////////////////
	// basic types
	//////////////////////////////////////////////////

	// console region, JP=0 US=1 EU=2
	typedef logic [1:0] region_t;
	// how the region is chosen
	typedef logic [1:0] region_mode_t;
	// header priority order
	typedef logic [1:0] region_prio_t;
	// eight ascii characters, first character in the top byte
	typedef logic [63:0] cart_id_t;
	// light gun sensor delay
	typedef logic [7:0] gun_delay_t;

	// per-title quirk flags
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

	//////////////////////////////////////////////////
	// codes
	//////////////////////////////////////////////////

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	// modes at or above REGION_MODE_OFF are disabled
	localparam region_mode_t REGION_MODE_FILE = 2'd0;
	localparam region_mode_t REGION_MODE_HDR  = 2'd1;
	localparam region_mode_t REGION_MODE_OFF  = 2'd2;

	localparam region_prio_t PRIO_UEJ = 2'd0;
	localparam region_prio_t PRIO_EUJ = 2'd1;
	localparam region_prio_t PRIO_UJE = 2'd2;
	localparam region_prio_t PRIO_JUE = 2'd3;

	// header word byte addresses
	localparam int unsigned HDR_ID0_ADDR    = 'h182;
	localparam int unsigned HDR_ID1_ADDR    = 'h184;
	localparam int unsigned HDR_ID2_ADDR    = 'h186;
	localparam int unsigned HDR_ID3_ADDR    = 'h188;
	localparam int unsigned HDR_ID4_ADDR    = 'h18A;
	localparam int unsigned HDR_QUIRK_ADDR  = 'h18C;
	localparam int unsigned HDR_REGION0_ADDR = 'h1F0;
	localparam int unsigned HDR_REGION1_ADDR = 'h1F2;
	localparam int unsigned HDR_END_ADDR    = 'h200;

	localparam gun_delay_t DEFAULT_GUN_DELAY = 8'd44;

endpackage

// ==== hdl/cheat_pkg.sv ====
// cheat code word layout
package cheat_pkg;

	//////////////////////////////////////////////////
	// code word
	//////////////////////////////////////////////////

	// number of 16-bit words in one code
	localparam int unsigned CHEAT_WORDS = 8;
	// byte offset of the final word, completes the code
	localparam int unsigned CHEAT_LAST_OFFSET = 14;

	// consumer view, 32-bit fields
	// replace sits on top so that load slot n lands in word n
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;
	} cheat_fields_t;

	// loader view is word[slot], slot = byte offset / 2
	// slot 0/1 flags lo/hi, 2/3 address, 4/5 compare, 6/7 replace
	typedef union packed {
		logic [CHEAT_WORDS-1:0][15:0] word;
		cheat_fields_t                field;
	} cheat_code_t;

endpackage

// ==== hdl/dl_bus_if.sv ====
// download bus
interface dl_bus_if #(
	parameter int DL_ADDR_W = 25
) ();

	// one-cycle write strobe
	logic                 wr;
	// byte address of the word
	logic [DL_ADDR_W-1:0] addr;
	logic [15:0]          data;
	// high for the whole download
	logic                 active;

	modport source (
		output wr, addr, data, active
	);

	modport sink (
		input wr, addr, data, active
	);

endinterface

// ==== hdl/header_scanner.sv ====
// cartridge header scanner
module header_scanner import cart_pkg::*; #(
	parameter int DL_ADDR_W = 25
) (
	input  logic       clk_sys,
	input  logic       RESET,
	dl_bus_if.sink     bus,
	output cart_id_t   cart_id,
	output logic       id_done,
	output logic       hdr_j,
	output logic       hdr_u,
	output logic       hdr_e,
	output logic       hdr_ready
);

	localparam logic [DL_ADDR_W-1:0] A_ID0   = DL_ADDR_W'(HDR_ID0_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_ID1   = DL_ADDR_W'(HDR_ID1_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_ID2   = DL_ADDR_W'(HDR_ID2_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_ID3   = DL_ADDR_W'(HDR_ID3_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_ID4   = DL_ADDR_W'(HDR_ID4_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_QUIRK = DL_ADDR_W'(HDR_QUIRK_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_REG0  = DL_ADDR_W'(HDR_REGION0_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_REG1  = DL_ADDR_W'(HDR_REGION1_ADDR);
	localparam logic [DL_ADDR_W-1:0] A_END   = DL_ADDR_W'(HDR_END_ADDR);

	logic       active_q;
	logic       hdr_wr;
	logic [2:0] region_hit;

	// one header byte as {j, u, e}
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] jue;
		jue = 3'b000;
		if (ch == "J") begin
			jue = 3'b100;
		end else if (ch == "U") begin
			jue = 3'b010;
		end else if (ch >= "0" && ch <= "Z") begin
			jue = 3'b001;
		end
		return jue;
	endfunction

	assign hdr_wr = bus.wr & bus.active;

	// 0x1F0 carries two region letters, 0x1F2 only one in the low byte
	always_comb begin
		region_hit = 3'b000;
		if (hdr_wr && bus.addr == A_REG0) begin
			region_hit = classify(bus.data[7:0]) | classify(bus.data[15:8]);
		end else if (hdr_wr && bus.addr == A_REG1) begin
			region_hit = classify(bus.data[7:0]);
		end
	end

	//////////////////////////////////////////////////
	// product id, words arrive low byte first
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (bus.addr)
				A_ID0: cart_id[63:56] <= bus.data[15:8];
				A_ID1: cart_id[55:40] <= {bus.data[7:0], bus.data[15:8]};
				A_ID2: cart_id[39:24] <= {bus.data[7:0], bus.data[15:8]};
				A_ID3: cart_id[23:8]  <= {bus.data[7:0], bus.data[15:8]};
				A_ID4: cart_id[7:0]   <= bus.data[7:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// flags and ready level
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			active_q  <= 1'b0;
			id_done   <= 1'b0;
			hdr_ready <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		end else begin
			active_q <= bus.active;
			// id is complete once the quirk word shows up
			id_done  <= hdr_wr && bus.addr == A_QUIRK;
			// new download starts with no letters seen
			if (bus.active && !active_q) begin
				{hdr_j, hdr_u, hdr_e} <= region_hit;
			end else begin
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | region_hit;
			end
			if (!bus.active && active_q) begin
				hdr_ready <= 1'b0;
			end else if (hdr_wr && bus.addr == A_END) begin
				hdr_ready <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/quirk_table.sv ====
// per-title quirk lookup
module quirk_table import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  cart_id_t   cart_id,
	input  logic       id_done,
	output quirk_t     quirks,
	output logic       gun_type,
	output gun_delay_t gun_delay
);

	quirk_t     quirk_next;
	logic       gun_type_next;
	gun_delay_t gun_delay_next;

	// quirk flags, at most one per title
	always_comb begin
		quirk_next = '0;
		case (cart_id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				quirk_next.sram = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				quirk_next.eeprom = 1'b1;
			// fake ram check in the game code
			"T-113016": quirk_next.noram = 1'b1;
			"T-89016 ": quirk_next.fifo = 1'b1;
			"T-574023", "T-574013": quirk_next.pier = 1'b1;
			// svp carts, both regions
			"MK-1229 ", "G-7001  ": quirk_next.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-":
				quirk_next.fmbusy = 1'b1;
			// question marks are literal, as stored in the header
			"T-68???-": quirk_next.schan = 1'b1;
			default: ;
		endcase
	end

	// light gun device and sensor timing
	always_comb begin
		gun_type_next  = 1'b0;
		gun_delay_next = DEFAULT_GUN_DELAY;
		case (cart_id)
			"MK-1533 ": gun_delay_next = 8'd100;
			"T-95096-": begin
				gun_type_next  = 1'b1;
				gun_delay_next = 8'd52;
			end
			"T-95136-": begin
				gun_type_next  = 1'b1;
				gun_delay_next = 8'd30;
			end
			"MK-1658 ": gun_delay_next = 8'd120;
			"T-081156": gun_delay_next = 8'd126;
			default: ;
		endcase
	end

	// reload everything once per id, unknown ids fall back to defaults
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= DEFAULT_GUN_DELAY;
		end else if (id_done) begin
			quirks    <= quirk_next;
			gun_type  <= gun_type_next;
			gun_delay <= gun_delay_next;
		end
	end

endmodule

// ==== hdl/region_select.sv ====
// console region selection
module region_select import cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         hdr_j,
	input  logic         hdr_u,
	input  logic         hdr_e,
	input  logic         hdr_ready,
	input  region_mode_t region_mode,
	input  region_prio_t region_prio,
	input  logic [7:0]   file_index,
	output region_t      region,
	output logic         region_set
);

	logic       ready_q;
	logic       mode_off;
	logic [2:0] hdr_flags;
	region_t    hdr_pick;

	// first flagged region of the order, else the first of the order
	function automatic region_t first_set(
		input logic [2:0] flags,
		input region_t    r0,
		input region_t    r1,
		input region_t    r2
	);
		region_t pick;
		pick = r0;
		if (flags[r0]) begin
			pick = r0;
		end else if (flags[r1]) begin
			pick = r1;
		end else if (flags[r2]) begin
			pick = r2;
		end
		return pick;
	endfunction

	// indexed by region code
	assign hdr_flags = {hdr_e, hdr_u, hdr_j};
	assign mode_off  = region_mode >= REGION_MODE_OFF;

	always_comb begin
		case (region_prio)
			PRIO_UEJ: hdr_pick = first_set(hdr_flags, REGION_US, REGION_EU, REGION_JP);
			PRIO_EUJ: hdr_pick = first_set(hdr_flags, REGION_EU, REGION_US, REGION_JP);
			PRIO_UJE: hdr_pick = first_set(hdr_flags, REGION_US, REGION_JP, REGION_EU);
			default:  hdr_pick = first_set(hdr_flags, REGION_JP, REGION_US, REGION_EU);
		endcase
	end

	//////////////////////////////////////////////////
	// decision on the header-ready edges
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region     <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			// disabled mode leaves both outputs alone
			if (!mode_off) begin
				if (hdr_ready && !ready_q) begin
					if (region_mode == REGION_MODE_HDR) begin
						region     <= hdr_pick;
						region_set <= 1'b1;
					end else begin
						// file extension index, region in the top bits
						region     <= file_index[7:6];
						region_set <= |file_index;
					end
				end else if (!hdr_ready && ready_q) begin
					region_set <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== hdl/cheat_loader.sv ====
// cheat code assembler
module cheat_loader import cheat_pkg::*; #(
	parameter int DL_ADDR_W = 25
) (
	input  logic        clk_sys,
	input  logic        RESET,
	dl_bus_if.sink      bus,
	output cheat_code_t cheat_code,
	output logic        code_valid,
	output logic        cheat_reset
);

	logic code_wr;
	logic last_word;

	// only even offsets 0 to 14 carry code words
	assign code_wr   = bus.wr & bus.active & ~bus.addr[0];
	assign last_word = bus.addr[3:0] == 4'(CHEAT_LAST_OFFSET);

	// restart of the code list, seen while the first word is written
	assign cheat_reset = bus.wr & bus.active & (bus.addr == {DL_ADDR_W{1'b0}});

	// slot is the word offset
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat_code.word[bus.addr[3:1]] <= bus.data;
		end
	end

	// one pulse when the replace high word lands
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr & last_word;
		end
	end

endmodule

// ==== hdl/rom_write_sync.sv ====
// rom write request sync
module rom_write_sync #(
	parameter int DL_ADDR_W = 25
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	dl_bus_if.sink               bus,
	input  logic                 rom_wr_ack,
	output logic                 rom_wr_req,
	output logic [DL_ADDR_W-2:0] rom_addr,
	output logic [15:0]          rom_data,
	output logic                 rom_wait
);

	logic rom_wr;

	assign rom_wr = bus.wr & bus.active;

	// word address and byte-swapped data for the memory
	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			rom_addr <= bus.addr[DL_ADDR_W-1:1];
			rom_data <= {bus.data[7:0], bus.data[15:8]};
		end
	end

	//////////////////////////////////////////////////
	// toggle request, wait until ack catches up
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_wr_req <= 1'b0;
			rom_wait   <= 1'b0;
		end else if (rom_wr) begin
			// an early write still goes out and toggles again
			rom_wr_req <= ~rom_wr_req;
			rom_wait   <= 1'b1;
		end else if (rom_wait && rom_wr_ack == rom_wr_req) begin
			rom_wait <= 1'b0;
		end
	end

endmodule

// ==== hdl/cart_frontend.sv ====
// cartridge download front end
module cart_frontend import cart_pkg::*, cheat_pkg::*; #(
	parameter int DL_ADDR_W = 25
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	// host download port
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [15:0]          dl_data,
	input  region_mode_t         region_mode,
	input  region_prio_t         region_prio,
	// rom memory port
	input  logic                 rom_wr_ack,
	output logic                 rom_wr_req,
	output logic [DL_ADDR_W-2:0] rom_addr,
	output logic [15:0]          rom_data,
	output logic                 rom_wait,
	// cartridge settings
	output quirk_t               quirks,
	output logic                 gun_type,
	output gun_delay_t           gun_delay,
	output region_t              region,
	output logic                 region_set,
	// cheat codes
	output cheat_code_t          cheat_code,
	output logic                 code_valid,
	output logic                 cheat_reset
);

	logic     code_index;
	cart_id_t cart_id;
	logic     id_done;
	logic     hdr_j, hdr_u, hdr_e;
	logic     hdr_ready;

	dl_bus_if #(.DL_ADDR_W(DL_ADDR_W)) cart_bus ();
	dl_bus_if #(.DL_ADDR_W(DL_ADDR_W)) cheat_bus ();

	//////////////////////////////////////////////////
	// index all ones is a cheat list, else a cart
	//////////////////////////////////////////////////
	assign code_index = &dl_index;

	assign cart_bus.active  = dl_active & ~code_index;
	assign cart_bus.wr      = dl_wr & dl_active & ~code_index;
	assign cart_bus.addr    = dl_addr;
	assign cart_bus.data    = dl_data;

	assign cheat_bus.active = dl_active & code_index;
	assign cheat_bus.wr     = dl_wr & dl_active & code_index;
	assign cheat_bus.addr   = dl_addr;
	assign cheat_bus.data   = dl_data;

	header_scanner #(.DL_ADDR_W(DL_ADDR_W)) u_header_scanner (
		.clk_sys, .RESET, .bus(cart_bus),
		.cart_id, .id_done, .hdr_j, .hdr_u, .hdr_e, .hdr_ready
	);

	quirk_table u_quirk_table (
		.clk_sys, .RESET, .cart_id, .id_done, .quirks, .gun_type, .gun_delay
	);

	region_select u_region_select (
		.clk_sys, .RESET, .hdr_j, .hdr_u, .hdr_e, .hdr_ready,
		.region_mode, .region_prio, .file_index(dl_index), .region, .region_set
	);

	cheat_loader #(.DL_ADDR_W(DL_ADDR_W)) u_cheat_loader (
		.clk_sys, .RESET, .bus(cheat_bus), .cheat_code, .code_valid, .cheat_reset
	);

	rom_write_sync #(.DL_ADDR_W(DL_ADDR_W)) u_rom_write_sync (
		.clk_sys, .RESET, .bus(cart_bus),
		.rom_wr_ack, .rom_wr_req, .rom_addr, .rom_data, .rom_wait
	);

endmodule

// ==== verification/tb_model.svh ====
// testbench reference model

//////////////////////////////////////////////////
// random numbers
//////////////////////////////////////////////////

// right-shift galois form, x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
endfunction

// one lfsr step per bit, first bit ends up on top
task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
	value = '0;
	for (int i = 0; i < n; i++) begin
		value = {value[30:0], state[0]};
		state = lfsr_next(state);
	end
endtask

//////////////////////////////////////////////////
// header rules
//////////////////////////////////////////////////

// candidates for the region bytes, some of them count for nothing
localparam logic [7:0] LETTER_POOL [8] = '{"J", "U", "E", "K", "0", "Z", "a", "-"};

// {j, u, e}; any other character from '0' to 'Z' means europe
function automatic logic [2:0] letter_jue(input logic [7:0] ch);
	logic in_range;
	in_range = (ch >= 8'h30) && (ch <= 8'h5A);
	return {ch == 8'h4A, ch == 8'h55, in_range && ch != 8'h4A && ch != 8'h55};
endfunction

// first flagged region of the order, else the head of the order
function automatic region_t region_by_priority(input logic [2:0] jue, input region_prio_t prio);
	region_t order [3];
	region_t pick;
	case (prio)
		2'd0: order = '{REGION_US, REGION_EU, REGION_JP};
		2'd1: order = '{REGION_EU, REGION_US, REGION_JP};
		2'd2: order = '{REGION_US, REGION_JP, REGION_EU};
		default: order = '{REGION_JP, REGION_US, REGION_EU};
	endcase
	pick = order[0];
	// walk backwards so the earliest hit wins
	for (int i = 2; i >= 0; i--) begin
		if ((order[i] == REGION_JP && jue[2]) || (order[i] == REGION_US && jue[1]) ||
				(order[i] == REGION_EU && jue[0])) begin
			pick = order[i];
		end
	end
	return pick;
endfunction

//////////////////////////////////////////////////
// known titles
//////////////////////////////////////////////////

// id, quirk flags (sram on top), gun type, gun delay
localparam int N_TITLES = 13;
localparam logic [80:0] KNOWN_TITLES [N_TITLES] = '{
	{"T-081276", 8'h80, 1'b0, 8'd44},
	{"MK-1215 ", 8'h40, 1'b0, 8'd44},
	{"T-89016 ", 8'h20, 1'b0, 8'd44},
	{"T-113016", 8'h10, 1'b0, 8'd44},
	{"T-574023", 8'h08, 1'b0, 8'd44},
	{"MK-1229 ", 8'h04, 1'b0, 8'd44},
	{"T-35036 ", 8'h02, 1'b0, 8'd44},
	{"T-68???-", 8'h01, 1'b0, 8'd44},
	{"MK-1533 ", 8'h00, 1'b0, 8'd100},
	{"T-95096-", 8'h00, 1'b1, 8'd52},
	{"T-95136-", 8'h00, 1'b1, 8'd30},
	{"MK-1658 ", 8'h00, 1'b0, 8'd120},
	{"T-081156", 8'h00, 1'b0, 8'd126}
};

// unknown ids give no quirks, gun type 0 and delay 44
task automatic title_lookup(input cart_id_t id, output quirk_t q, output logic gt,
		output gun_delay_t gd);
	q  = '0;
	gt = 1'b0;
	gd = 8'd44;
	for (int i = 0; i < N_TITLES; i++) begin
		if (KNOWN_TITLES[i][80:17] == id) begin
			{q, gt, gd} = KNOWN_TITLES[i][16:0];
		end
	end
endtask

//////////////////////////////////////////////////
// compares, one per result kind
//////////////////////////////////////////////////

task automatic rom_word_check(input logic [DL_ADDR_W-2:0] got_addr, exp_addr,
		input logic [15:0] got_data, exp_data);
	if (got_addr !== exp_addr || got_data !== exp_data) begin
		err_rom++;
		$display("[FAIL] %0t ns rom word %h:%h, expected %h:%h", $time,
			got_addr, got_data, exp_addr, exp_data);
	end
endtask

task automatic quirk_check(input quirk_t got, input quirk_t exp);
	if (got !== exp) begin
		err_quirk++;
		$display("[FAIL] %0t ns quirks %b, expected %b", $time, got, exp);
	end
endtask

task automatic gun_check(input logic got_type, exp_type, input gun_delay_t got_delay,
		exp_delay);
	if (got_type !== exp_type || got_delay !== exp_delay) begin
		err_gun++;
		$display("[FAIL] %0t ns gun %b/%0d, expected %b/%0d", $time,
			got_type, got_delay, exp_type, exp_delay);
	end
endtask

task automatic region_check(input region_t got, input region_t exp, input logic got_set,
		exp_set);
	if (got !== exp || got_set !== exp_set) begin
		err_region++;
		$display("[FAIL] %0t ns region %0d set %b, expected %0d set %b", $time,
			got, got_set, exp, exp_set);
	end
endtask

task automatic cheat_check(input cheat_code_t got, input cheat_code_t exp);
	if (got !== exp) begin
		err_cheat++;
		$display("[FAIL] %0t ns cheat %h %h %h %h, expected %h %h %h %h", $time,
			got.field.flags, got.field.address, got.field.compare, got.field.replace,
			exp.field.flags, exp.field.address, exp.field.compare, exp.field.replace);
	end
endtask

// protocol problems, no value to show
task automatic report_error(input string what);
	err_other++;
	$display("Error at %0t ns: %s", $time, what);
endtask

// ==== verification/tb_cart_frontend.sv ====
// cartridge front end testbench
module tb_cart_frontend import cart_pkg::*, cheat_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DL_ADDR_W   = 25;
	// words 0x000 to 0x200 of each cartridge header
	localparam int HDR_WORDS   = 257;
	localparam int CART_RUNS   = 11;
	localparam int CHEAT_RUNS  = 4;
	localparam int TOTAL_WORDS = CART_RUNS * HDR_WORDS + CHEAT_RUNS * 8;
	localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 1000;

	logic                 clk_sys = 1'b0;
	logic                 RESET;
	logic                 dl_active;
	logic                 dl_wr;
	logic [7:0]           dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [15:0]          dl_data;
	region_mode_t         region_mode;
	region_prio_t         region_prio;
	logic                 rom_wr_ack = 1'b0;
	logic                 rom_wr_req;
	logic [DL_ADDR_W-2:0] rom_addr;
	logic [15:0]          rom_data;
	logic                 rom_wait;
	quirk_t               quirks;
	logic                 gun_type;
	gun_delay_t           gun_delay;
	region_t              region;
	logic                 region_set;
	cheat_code_t          cheat_code;
	logic                 code_valid;
	logic                 cheat_reset;

	// separate streams, same seed, so draw order never depends on scheduling
	logic [31:0] stim_lfsr = 32'd79661;
	logic [31:0] ack_lfsr  = 32'd79661;
	logic [31:0] ack_draw;
	int          ack_count   = 0;
	int          cycle_count = 0;

	int err_rom    = 0;
	int err_quirk  = 0;
	int err_gun    = 0;
	int err_region = 0;
	int err_cheat  = 0;
	int err_other  = 0;

	// model state
	logic [7:0] img [0:'h201];
	logic       exp_req = 1'b0;
	quirk_t     exp_quirk;
	logic       exp_gun_type;
	gun_delay_t exp_gun_delay;
	region_t    exp_region = REGION_JP;
	logic       exp_set = 1'b0;

	`include "tb_model.svh"

	cart_frontend #(.DL_ADDR_W(DL_ADDR_W)) u_dut (
		.clk_sys, .RESET, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.region_mode, .region_prio, .rom_wr_ack, .rom_wr_req, .rom_addr, .rom_data,
		.rom_wait, .quirks, .gun_type, .gun_delay, .region, .region_set,
		.cheat_code, .code_valid, .cheat_reset
	);

	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// memory side and run limit
	//////////////////////////////////////////////////

	// ack follows the request after 0 to 7 cycles
	always @(negedge clk_sys) begin
		if (ack_count > 0) begin
			ack_count = ack_count - 1;
			if (ack_count == 0) begin
				rom_wr_ack <= rom_wr_req;
			end
		end else if (rom_wr_req !== rom_wr_ack && !RESET) begin
			draw_bits(ack_lfsr, 3, ack_draw);
			if (ack_draw[2:0] == 3'd0) begin
				rom_wr_ack <= rom_wr_req;
			end else begin
				ack_count = int'(ack_draw[2:0]);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus tasks, entered on a falling edge
	//////////////////////////////////////////////////

	task automatic write_cart_word(input int a);
		logic [DL_ADDR_W-2:0] exp_addr;
		exp_addr = a[DL_ADDR_W-1:1];
		dl_addr  = a[DL_ADDR_W-1:0];
		// header byte at the even address sits in the low half
		dl_data  = {img[a+1], img[a]};
		dl_wr    = 1'b1;
		exp_req  = ~exp_req;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		if (rom_wr_req !== exp_req) begin
			report_error("rom_wr_req did not toggle after a cartridge write");
		end
		if (rom_wait !== 1'b1) begin
			report_error("rom_wait was not raised after a cartridge write");
		end
		rom_word_check(rom_addr, exp_addr, rom_data, {img[a], img[a+1]});
		// two cycles after the write
		@(negedge clk_sys);
		if (a == 'h18C) begin
			quirk_check(quirks, exp_quirk);
			gun_check(gun_type, exp_gun_type, gun_delay, exp_gun_delay);
		end
		if (a == 'h200) begin
			region_check(region, exp_region, region_set, exp_set);
		end
		// host holds off while the memory is busy
		while (rom_wait) begin
			@(negedge clk_sys);
		end
		if (rom_wr_ack !== rom_wr_req) begin
			report_error("rom_wait fell before the acknowledge matched the request");
		end
	endtask

	task automatic run_cart_download(input region_mode_t mode, input region_prio_t prio,
			input logic zero_index);
		logic [31:0] v;
		cart_id_t    id;
		logic [7:0]  index;
		logic [2:0]  jue;
		int          a;
		for (a = 0; a < 'h202; a++) begin
			draw_bits(stim_lfsr, 8, v);
			img[a] = v[7:0];
		end
		// tabled title or a made-up one
		draw_bits(stim_lfsr, 1, v);
		if (v[0]) begin
			draw_bits(stim_lfsr, 4, v);
			id = KNOWN_TITLES[int'(v[3:0]) % N_TITLES][80:17];
		end else begin
			id = '0;
			for (int k = 0; k < 8; k++) begin
				draw_bits(stim_lfsr, 8, v);
				id = {id[55:0], v[7:0]};
			end
		end
		// product id occupies bytes 0x183 to 0x18A
		for (int k = 0; k < 8; k++) begin
			img['h183 + k] = id[63 - 8 * k -: 8];
		end
		for (int k = 0; k < 3; k++) begin
			draw_bits(stim_lfsr, 3, v);
			img['h1F0 + k] = LETTER_POOL[v[2:0]];
		end
		jue = letter_jue(img['h1F0]) | letter_jue(img['h1F1]) | letter_jue(img['h1F2]);
		title_lookup(id, exp_quirk, exp_gun_type, exp_gun_delay);
		draw_bits(stim_lfsr, 8, v);
		index = zero_index ? 8'h00 : v[7:0];
		// all ones would turn the download into a cheat list
		if (index == 8'hFF) begin
			index = 8'hFE;
		end
		if (mode == REGION_MODE_HDR) begin
			exp_region = region_by_priority(jue, prio);
			exp_set    = 1'b1;
		end else if (mode == REGION_MODE_FILE) begin
			exp_region = index[7:6];
			exp_set    = |index;
		end
		region_mode = mode;
		region_prio = prio;
		dl_index    = index;
		dl_active   = 1'b1;
		@(negedge clk_sys);
		for (a = 0; a <= 'h200; a += 2) begin
			write_cart_word(a);
		end
		dl_active = 1'b0;
		// ready drops, then region_set a cycle later
		repeat (2) @(negedge clk_sys);
		if (mode < REGION_MODE_OFF) begin
			exp_set = 1'b0;
		end
		region_check(region, exp_region, region_set, exp_set);
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic write_cheat_word(input int off, input logic [15:0] data, input logic last);
		dl_addr = off[DL_ADDR_W-1:0];
		dl_data = data;
		dl_wr   = 1'b1;
		// reset flag is combinational, look mid low phase
		#10;
		if (cheat_reset !== (off == 0)) begin
			report_error(off == 0 ? "cheat_reset missing on the write to address 0" :
				"cheat_reset seen on a write to a nonzero address");
		end
		@(negedge clk_sys);
		dl_wr = 1'b0;
		if (code_valid !== last) begin
			report_error(last ? "code_valid missing after the last cheat word" :
				"code_valid raised before the last cheat word");
		end
	endtask

	task automatic run_cheat_code();
		logic [31:0] v;
		logic [15:0] words [8];
		int          order [8];
		int          j;
		int          t;
		cheat_code_t exp;
		for (int i = 0; i < 8; i++) begin
			order[i] = i;
		end
		// shuffle slots 0 to 6, slot 7 (offset 14) stays last
		for (int i = 6; i > 0; i--) begin
			draw_bits(stim_lfsr, 3, v);
			j = int'(v[2:0]) % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		dl_index  = 8'hFF;
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 8; i++) begin
			draw_bits(stim_lfsr, 16, v);
			words[order[i]] = v[15:0];
			write_cheat_word(order[i] * 2, v[15:0], i == 7);
		end
		exp.field.flags   = {words[1], words[0]};
		exp.field.address = {words[3], words[2]};
		exp.field.compare = {words[5], words[4]};
		exp.field.replace = {words[7], words[6]};
		cheat_check(cheat_code, exp);
		@(negedge clk_sys);
		if (code_valid !== 1'b0) begin
			report_error("code_valid stayed high for more than one cycle");
		end
		if (rom_wr_req !== exp_req) begin
			report_error("a cheat word reached the ROM port");
		end
		dl_active = 1'b0;
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = 8'h00;
		dl_addr     = '0;
		dl_data     = 16'h0000;
		region_mode = REGION_MODE_HDR;
		region_prio = PRIO_UEJ;
		repeat (3) @(negedge clk_sys);
		// outputs come out of reset inactive, gun delay at its default
		quirk_check(quirks, '0);
		gun_check(gun_type, 1'b0, gun_delay, 8'd44);
		if (rom_wait !== 1'b0 || region_set !== 1'b0 || code_valid !== 1'b0) begin
			report_error("an output was still active after reset");
		end
		RESET = 1'b0;
		@(negedge clk_sys);
		// header mode, each priority twice
		for (int p = 0; p < 8; p++) begin
			run_cart_download(REGION_MODE_HDR, region_prio_t'(p % 4), 1'b0);
		end
		run_cart_download(REGION_MODE_FILE, PRIO_UEJ, 1'b1);
		run_cart_download(REGION_MODE_FILE, PRIO_JUE, 1'b0);
		// mode 3 is disabled as well as mode 2
		run_cart_download(2'd3, PRIO_EUJ, 1'b0);
		for (int c = 0; c < CHEAT_RUNS; c++) begin
			run_cheat_code();
		end
		$display("Errors: rom %0d, quirk %0d, gun %0d, region %0d, cheat %0d, other %0d",
			err_rom, err_quirk, err_gun, err_region, err_cheat, err_other);
		if (err_rom + err_quirk + err_gun + err_region + err_cheat + err_other == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+verification
hdl/cart_pkg.sv
hdl/cheat_pkg.sv
hdl/dl_bus_if.sv
hdl/header_scanner.sv
hdl/quirk_table.sv
hdl/region_select.sv
hdl/cheat_loader.sv
hdl/rom_write_sync.sv
hdl/cart_frontend.sv
verification/tb_cart_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module tb_cart_frontend -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi
./obj_dir/Vtb_cart_frontend > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
if grep -q "Done: errors found" sim.log; then
	exit 1
fi
exit 0
